// ==== alu_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module alu_unit (
    input  logic                clk,
    input  logic                rst,
    input  ooo_pkg::exec_req_t  req,
    input  logic                flush,
    output ooo_pkg::cdb_pkt_t   pkt
);
    import ooo_pkg::*;

    cdb_pkt_t s1_next;
    cdb_pkt_t s1;

    // stage one
    always_comb begin
        s1_next.valid = req.valid;
        s1_next.tag   = req.tag;
        s1_next.value = '0;
        s1_next.taken = 1'b0;
        case (req.instr.op)
            OP_ADD: begin
                s1_next.value = req.instr.a + req.instr.b;
            end
            OP_SUB: begin
                s1_next.value = req.instr.a - req.instr.b;
            end
            OP_AND: begin
                s1_next.value = req.instr.a & req.instr.b;
            end
            OP_XOR: begin
                s1_next.value = req.instr.a ^ req.instr.b;
            end
            OP_BEQ: begin
                // branch outcome only, no register result
                s1_next.taken = req.instr.a == req.instr.b;
            end
            default: begin
                s1_next.value = '0;
            end
        endcase
    end

    // stage two holds the packet for the arbiter
    always_ff @(posedge clk) begin
        s1  <= s1_next;
        pkt <= s1;
        if (rst || flush) begin
            s1.valid  <= 1'b0;
            pkt.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== cdb_arbiter.sv ====
`timescale 1ns/100ps
`default_nettype none

module cdb_arbiter (
    input  logic               clk,
    input  logic               rst,
    input  ooo_pkg::cdb_pkt_t  alu_pkt,
    input  ooo_pkg::cdb_pkt_t  sb_pkt,
    output ooo_pkg::cdb_pkt_t  cdb,
    output logic               sb_grant
);
    import ooo_pkg::*;

    cdb_pkt_t sel;

    // alu cannot stall, so it always wins
    assign sb_grant = sb_pkt.valid && !alu_pkt.valid;

    always_comb begin
        if (alu_pkt.valid) begin
            sel = alu_pkt;
        end else begin
            sel = sb_pkt;
        end
    end

    // registered bus stage
    always_ff @(posedge clk) begin
        cdb <= sel;
        if (rst) begin
            cdb.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== ooo_core_assertions.sv ====
`timescale 1ns/100ps
`default_nettype none

module ooo_core_assertions (
    input logic             clk,
    input logic             rst,
    input logic             issue_ready,
    input ooo_pkg::commit_t commit,
    input logic             store_release,
    input logic             flush,
    input ooo_pkg::mem_wr_t mem_wr
);
    int unsigned fail_count = 0;
    logic        rst_seen = 1'b0;

    // outputs are defined once the first reset edge has passed
    always @(posedge clk) begin
        if (rst) begin
            rst_seen <= 1'b1;
        end
    end

    a_one_retire_event: assert property (@(posedge clk) disable iff (rst)
        $onehot0({commit.valid, store_release, flush}))
    else begin
        fail_count = fail_count + 1;
        $error("commit, release and flush active in the same cycle");
    end

    a_flush_pulse: assert property (@(posedge clk) disable iff (rst)
        flush |=> !flush)
    else begin
        fail_count = fail_count + 1;
        $error("flush held longer than one cycle");
    end

    a_no_issue_in_flush: assert property (@(posedge clk) disable iff (rst)
        flush |-> !issue_ready)
    else begin
        fail_count = fail_count + 1;
        $error("issue_ready high while flush is active");
    end

    a_quiet_in_reset: assert property (@(posedge clk)
        rst && rst_seen |-> !commit.valid && !store_release && !flush && !mem_wr.valid)
    else begin
        fail_count = fail_count + 1;
        $error("output strobe active during reset");
    end

endmodule

`default_nettype wire

// ==== ooo_core_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module ooo_core_top (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      issue_en,
    input  ooo_pkg::instr_t           issue,
    output logic                      issue_ready,
    output ooo_pkg::commit_t          commit,
    output ooo_pkg::mem_wr_t          mem_wr,
    output logic                      flush,
    output logic [ooo_pkg::XLEN-1:0]  redirect_pc
);
    import ooo_pkg::*;

    exec_req_t alu_req;
    exec_req_t sb_req;
    cdb_pkt_t  alu_pkt;
    cdb_pkt_t  sb_pkt;
    cdb_pkt_t  cdb;
    logic      sb_full;
    logic      sb_grant;
    logic      store_release;

    reorder_buffer u_rob (
        .clk           (clk),
        .rst           (rst),
        .issue_en      (issue_en),
        .issue         (issue),
        .issue_ready   (issue_ready),
        .alu_req       (alu_req),
        .sb_req        (sb_req),
        .sb_full       (sb_full),
        .cdb           (cdb),
        .commit        (commit),
        .store_release (store_release),
        .flush         (flush),
        .redirect_pc   (redirect_pc)
    );

    alu_unit u_alu (
        .clk   (clk),
        .rst   (rst),
        .req   (alu_req),
        .flush (flush),
        .pkt   (alu_pkt)
    );

    store_buffer u_sb (
        .clk           (clk),
        .rst           (rst),
        .req           (sb_req),
        .grant         (sb_grant),
        .store_release (store_release),
        .flush         (flush),
        .full          (sb_full),
        .pkt           (sb_pkt),
        .mem_wr        (mem_wr)
    );

    cdb_arbiter u_arb (
        .clk      (clk),
        .rst      (rst),
        .alu_pkt  (alu_pkt),
        .sb_pkt   (sb_pkt),
        .cdb      (cdb),
        .sb_grant (sb_grant)
    );

endmodule

`default_nettype wire

// ==== ooo_pkg.sv ====
`default_nettype none

package ooo_pkg;

    // core sizing
    localparam int ROB_DEPTH = 16;
    localparam int TAG_W     = 4;
    localparam int XLEN      = 32;
    localparam int RD_W      = 5;
    localparam int SB_DEPTH  = 4;
    localparam int SB_IDX_W  = $clog2(SB_DEPTH);

    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_AND = 3'd2,
        OP_XOR = 3'd3,
        OP_BEQ = 3'd4,
        OP_SW  = 3'd5
    } op_e;

    // operands already read by the front end
    typedef struct packed {
        op_e             op;
        logic [RD_W-1:0] rd;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] target;
        logic            pred_taken;
    } instr_t;

    typedef struct packed {
        logic             valid;
        logic [TAG_W-1:0] tag;
        instr_t           instr;
    } exec_req_t;

    typedef struct packed {
        logic             valid;
        logic [TAG_W-1:0] tag;
        logic [XLEN-1:0]  value;
        logic             taken;
    } cdb_pkt_t;

    typedef struct packed {
        logic            valid;
        logic [RD_W-1:0] rd;
        logic [XLEN-1:0] value;
    } commit_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] data;
    } mem_wr_t;

endpackage

`default_nettype wire

// ==== reorder_buffer.sv ====
`timescale 1ns/100ps
`default_nettype none

module reorder_buffer (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         issue_en,
    input  ooo_pkg::instr_t              issue,
    output logic                         issue_ready,
    output ooo_pkg::exec_req_t           alu_req,
    output ooo_pkg::exec_req_t           sb_req,
    input  logic                         sb_full,
    input  ooo_pkg::cdb_pkt_t            cdb,
    output ooo_pkg::commit_t             commit,
    output logic                         store_release,
    output logic                         flush,
    output logic [ooo_pkg::XLEN-1:0]     redirect_pc
);
    import ooo_pkg::*;

    typedef enum logic [1:0] {
        K_ARITH,
        K_BRANCH,
        K_STORE
    } kind_e;

    typedef struct packed {
        logic [RD_W-1:0] rd;
        logic [XLEN-1:0] value;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] target;
        logic            pred_taken;
        logic            taken;
        logic            done;
        kind_e           kind;
    } rob_entry_t;

    rob_entry_t ent [ROB_DEPTH];
    logic [ROB_DEPTH-1:0] ent_valid;

    logic [TAG_W-1:0] head;
    logic [TAG_W-1:0] tail;
    logic [TAG_W:0]   count;

    rob_entry_t new_ent;
    rob_entry_t head_ent;
    logic       rob_full;
    logic       accept;
    logic       retire;
    logic       mispredict;

    assign rob_full = count == (TAG_W + 1)'(ROB_DEPTH);

    // stores also need room in the store buffer
    assign issue_ready = !rob_full && !flush && !(issue.op == OP_SW && sb_full);
    assign accept      = issue_en && issue_ready;

    // dispatch in the same cycle as allocation
    always_comb begin
        alu_req.valid = accept && issue.op != OP_SW;
        alu_req.tag   = tail;
        alu_req.instr = issue;
        sb_req.valid  = accept && issue.op == OP_SW;
        sb_req.tag    = tail;
        sb_req.instr  = issue;
    end

    always_comb begin
        new_ent.rd         = issue.rd;
        new_ent.value      = '0;
        new_ent.pc         = issue.pc;
        new_ent.target     = issue.target;
        new_ent.pred_taken = issue.pred_taken;
        new_ent.taken      = 1'b0;
        new_ent.done       = 1'b0;
        case (issue.op)
            OP_SW:   new_ent.kind = K_STORE;
            OP_BEQ:  new_ent.kind = K_BRANCH;
            default: new_ent.kind = K_ARITH;
        endcase
    end

    assign head_ent = ent[head];

    // store data already sits in the store buffer, so no need to wait
    assign retire     = count != '0 && (head_ent.kind == K_STORE || head_ent.done);
    assign mispredict = retire && head_ent.kind == K_BRANCH &&
                        head_ent.taken != head_ent.pred_taken;

    always_comb begin
        commit.valid  = retire && head_ent.kind == K_ARITH;
        commit.rd     = head_ent.rd;
        commit.value  = head_ent.value;
        store_release = retire && head_ent.kind == K_STORE;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head      <= '0;
            tail      <= '0;
            count     <= '0;
            ent_valid <= '0;
            flush     <= 1'b0;
        end else begin
            flush <= mispredict;
            if (mispredict) begin
                // whole window is younger than the branch
                head      <= '0;
                tail      <= '0;
                count     <= '0;
                ent_valid <= '0;
            end else begin
                // stale packets after a flush find no live entry
                if (cdb.valid && ent_valid[cdb.tag]) begin
                    ent[cdb.tag].value <= cdb.value;
                    ent[cdb.tag].taken <= cdb.taken;
                    ent[cdb.tag].done  <= 1'b1;
                end
                if (accept) begin
                    ent[tail]       <= new_ent;
                    ent_valid[tail] <= 1'b1;
                    tail            <= tail + TAG_W'(1);
                end
                if (retire) begin
                    ent_valid[head] <= 1'b0;
                    head            <= head + TAG_W'(1);
                end
                count <= count + (TAG_W + 1)'(accept) - (TAG_W + 1)'(retire);
            end
        end
    end

    // fall-through or taken path of the resolved branch
    always_ff @(posedge clk) begin
        if (mispredict) begin
            redirect_pc <= head_ent.taken ? head_ent.target : head_ent.pc + 32'd4;
        end
    end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# build with Verilator, run, and pass only when the testbench reports success
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert --top-module tb_ooo_core -f sim.f -o sim_ooo_core \
    && ./obj_dir/sim_ooo_core | tee /dev/stderr | grep -q "NO ERRORS" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// ==== sim.f ====
ooo_pkg.sv
reorder_buffer.sv
alu_unit.sv
store_buffer.sv
cdb_arbiter.sv
ooo_core_top.sv
ooo_core_assertions.sv
tb_ooo_core.sv

// ==== store_buffer.sv ====
`timescale 1ns/100ps
`default_nettype none

module store_buffer (
    input  logic                clk,
    input  logic                rst,
    input  ooo_pkg::exec_req_t  req,
    input  logic                grant,
    input  logic                store_release,
    input  logic                flush,
    output logic                full,
    output ooo_pkg::cdb_pkt_t   pkt,
    output ooo_pkg::mem_wr_t    mem_wr
);
    import ooo_pkg::*;

    typedef struct packed {
        logic [TAG_W-1:0] tag;
        logic [XLEN-1:0]  addr;
        logic [XLEN-1:0]  data;
    } sb_entry_t;

    sb_entry_t q [SB_DEPTH];

    // order in the ring is head, cmt_ptr, tail
    logic [SB_IDX_W-1:0] head;
    logic [SB_IDX_W-1:0] cmt_ptr;
    logic [SB_IDX_W-1:0] tail;
    logic [SB_IDX_W-1:0] rep_idx;

    logic [SB_IDX_W:0] n_com;
    logic [SB_IDX_W:0] n_unc;
    logic [SB_IDX_W:0] n_rep;
    logic [SB_IDX_W:0] n_rep_inc;
    logic [SB_IDX_W:0] n_total;

    logic push;
    logic drain;

    assign n_total = n_com + n_unc;
    assign full    = n_total == (SB_IDX_W + 1)'(SB_DEPTH);
    assign push    = req.valid && !flush;
    assign drain   = n_com != '0;

    // oldest uncommitted store not yet on the bus
    assign rep_idx = cmt_ptr + n_rep[SB_IDX_W-1:0];

    always_comb begin
        pkt.valid = n_rep < n_unc;
        pkt.tag   = q[rep_idx].tag;
        pkt.value = q[rep_idx].data;
        pkt.taken = 1'b0;
    end

    // a committed store never needs its report
    assign n_rep_inc = n_rep + (SB_IDX_W + 1)'(grant);

    always_ff @(posedge clk) begin
        if (rst) begin
            head    <= '0;
            cmt_ptr <= '0;
            tail    <= '0;
            n_com   <= '0;
            n_unc   <= '0;
            n_rep   <= '0;
        end else begin
            if (drain) begin
                head <= head + SB_IDX_W'(1);
            end
            if (store_release) begin
                cmt_ptr <= cmt_ptr + SB_IDX_W'(1);
            end
            n_com <= n_com + (SB_IDX_W + 1)'(store_release) - (SB_IDX_W + 1)'(drain);
            if (flush) begin
                // committed stores still go to memory
                tail  <= cmt_ptr;
                n_unc <= '0;
                n_rep <= '0;
            end else begin
                if (push) begin
                    tail <= tail + SB_IDX_W'(1);
                end
                n_unc <= n_unc + (SB_IDX_W + 1)'(push) - (SB_IDX_W + 1)'(store_release);
                if (store_release && n_rep_inc != '0) begin
                    n_rep <= n_rep_inc - (SB_IDX_W + 1)'(1);
                end else begin
                    n_rep <= n_rep_inc;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            q[tail] <= '{tag: req.tag, addr: req.instr.a, data: req.instr.b};
        end
    end

    // one memory write per cycle, in release order
    always_ff @(posedge clk) begin
        if (rst) begin
            mem_wr.valid <= 1'b0;
        end else begin
            mem_wr.valid <= drain;
        end
        if (drain) begin
            mem_wr.addr <= q[head].addr;
            mem_wr.data <= q[head].data;
        end
    end

endmodule

`default_nettype wire

// ==== tb_ooo_core.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_ooo_core;
    import ooo_pkg::*;

    logic            clk;
    logic            rst;
    logic            issue_en;
    instr_t          issue;
    logic            issue_ready;
    commit_t         commit;
    mem_wr_t         mem_wr;
    logic            flush;
    logic [XLEN-1:0] redirect_pc;

    integer          seed = 32'h3101;
    logic [XLEN-1:0] next_pc;
    // program order of accepted work, and stores already released
    instr_t          exp_q[$];
    instr_t          mem_q[$];

    ooo_core_top DUT (
        .clk         (clk),
        .rst         (rst),
        .issue_en    (issue_en),
        .issue       (issue),
        .issue_ready (issue_ready),
        .commit      (commit),
        .mem_wr      (mem_wr),
        .flush       (flush),
        .redirect_pc (redirect_pc)
    );

    bind ooo_core_top ooo_core_assertions u_assert (
        .clk           (clk),
        .rst           (rst),
        .issue_ready   (issue_ready),
        .commit        (commit),
        .store_release (store_release),
        .flush         (flush),
        .mem_wr        (mem_wr)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic report_failure(string msg);
        $display("ERROR %0t: %s", $time, msg);
        $display("ERRORS FOUND");
        $fatal(1, "stopped at the first error");
    endtask

    function automatic logic [XLEN-1:0] alu_result(instr_t ins);
        case (ins.op)
            OP_ADD:  return ins.a + ins.b;
            OP_SUB:  return ins.a - ins.b;
            OP_AND:  return ins.a & ins.b;
            default: return ins.a ^ ins.b;
        endcase
    endfunction

    function automatic logic mispredicted(instr_t ins);
        return ins.op == OP_BEQ && ((ins.a == ins.b) != ins.pred_taken);
    endfunction

    function automatic instr_t random_instr();
        instr_t      ins;
        logic [31:0] rnd;
        logic [31:0] other;
        rnd   = $random(seed);
        other = $random(seed);
        case (rnd[2:0])
            3'd0, 3'd1: ins.op = OP_SW;
            3'd2:       ins.op = rnd[3] ? OP_BEQ : OP_ADD;
            3'd3:       ins.op = OP_SUB;
            3'd4:       ins.op = OP_AND;
            3'd5:       ins.op = OP_XOR;
            default:    ins.op = OP_ADD;
        endcase
        ins.rd         = rnd[12:8];
        ins.a          = $random(seed);
        ins.b          = rnd[13] ? ins.a : other;
        ins.pc         = next_pc;
        ins.target     = {other[31:2], 2'b00};
        ins.pred_taken = rnd[14];
        next_pc        = next_pc + 32'd4;
        return ins;
    endfunction

    // stores and correct branches leave the window without a visible commit
    task automatic retire_silent();
        while (exp_q.size() != 0 && (exp_q[0].op == OP_SW ||
               (exp_q[0].op == OP_BEQ && !mispredicted(exp_q[0])))) begin
            if (exp_q[0].op == OP_SW) begin
                mem_q.push_back(exp_q[0]);
            end
            void'(exp_q.pop_front());
        end
    endtask

    task automatic check_commit();
        instr_t ins;
        retire_silent();
        assert (exp_q.size() != 0 && exp_q[0].op inside {OP_ADD, OP_SUB, OP_AND, OP_XOR})
            else report_failure("register write with no arithmetic instruction at the head");
        ins = exp_q.pop_front();
        assert (commit.rd == ins.rd && commit.value == alu_result(ins))
            else report_failure($sformatf("commit rd %0d value %h, expected rd %0d value %h",
                                          commit.rd, commit.value, ins.rd, alu_result(ins)));
    endtask

    task automatic check_mem_wr();
        instr_t ins;
        if (mem_q.size() == 0) begin
            retire_silent();
        end
        assert (mem_q.size() != 0)
            else report_failure("memory write before all older instructions committed");
        ins = mem_q.pop_front();
        assert (mem_wr.addr == ins.a && mem_wr.data == ins.b)
            else report_failure($sformatf("mem write %h <= %h, expected %h <= %h",
                                          mem_wr.addr, mem_wr.data, ins.a, ins.b));
    endtask

    task automatic check_flush();
        logic [XLEN-1:0] exp_pc;
        retire_silent();
        assert (exp_q.size() != 0 && mispredicted(exp_q[0]))
            else report_failure("flush without a mispredicted branch at the head");
        exp_pc = (exp_q[0].a == exp_q[0].b) ? exp_q[0].target : exp_q[0].pc + 32'd4;
        assert (redirect_pc == exp_pc)
            else report_failure($sformatf("redirect_pc %h, expected %h", redirect_pc, exp_pc));
        // everything younger than the branch is gone
        exp_q.delete();
    endtask

    function automatic int pending();
        int n;
        n = mem_q.size();
        foreach (exp_q[i]) begin
            if (exp_q[i].op != OP_BEQ || mispredicted(exp_q[i])) begin
                n++;
            end
        end
        return n;
    endfunction

    // outputs only move on rising edges
    always @(negedge clk) begin
        if (!rst) begin
            assert (DUT.u_assert.fail_count == 0)
                else report_failure("a bound protocol assertion failed");
            if (flush) begin
                check_flush();
            end
            if (commit.valid) begin
                check_commit();
            end
            if (mem_wr.valid) begin
                check_mem_wr();
            end
        end
    end

    initial begin
        int n_issued;
        int stall;
        int wait_cycles;
        issue_en = 1'b0;
        issue    = '0;
        next_pc  = 32'h0000_1000;
        rst      = 1'b1;
        repeat (8) @(negedge clk);
        rst = 1'b0;
        #1;
        assert (issue_ready && !commit.valid && !flush && !mem_wr.valid)
            else report_failure("strobes active or issue_ready low after reset");

        n_issued = 0;
        stall    = 0;
        while (n_issued < 400) begin
            @(negedge clk);
            if (stall == 0) begin
                issue_en = ($random(seed) & 3) != 0;
                issue    = random_instr();
            end
            #1;
            if (issue_en && issue_ready) begin
                exp_q.push_back(issue);
                n_issued++;
                stall = 0;
            end else if (issue_en) begin
                stall++;
                assert (stall < 50) else report_failure("timeout waiting for issue_ready");
            end
        end
        @(negedge clk);
        issue_en = 1'b0;

        wait_cycles = 0;
        while (pending() != 0) begin
            assert (wait_cycles < 200)
                else report_failure("timeout waiting for the back end to drain");
            wait_cycles++;
            @(posedge clk);
        end
        repeat (20) @(posedge clk);
        if (DUT.u_assert.fail_count != 0) begin
            report_failure("a bound protocol assertion failed");
        end else begin
            $display("NO ERRORS");
            $finish;
        end
    end

endmodule

`default_nettype wire
